// File: ac_consts.svh
`ifndef AC_CONSTS_SVH
`define AC_CONSTS_SVH

// ---------------------------------------------------------------------------
// coder format widths
// ---------------------------------------------------------------------------
`define AC_RANGE_WIDTH  16
`define AC_LOW_WIDTH    24
`define AC_SYMBOL_WIDTH 4
`define AC_D_SIZE       5

// range after reset, half of the Q16 interval
`define AC_RANGE_RESET  32768

// per-symbol floor on the probability
`define AC_MIN_PROB     4

// flow control depths
`define AC_IN_CREDITS   2
`define AC_OUT_CREDITS  4

`endif

// File: ac_pkg.sv
`include "ac_consts.svh"

package ac_pkg;

    // coding rule for one symbol
    typedef enum logic {
        AC_MODE_MULTI = 1'b0,
        AC_MODE_BOOL  = 1'b1
    } ac_mode_e;

    // one input symbol as it enters the queue
    typedef struct packed {
        logic [`AC_RANGE_WIDTH-1:0]  fl;
        logic [`AC_RANGE_WIDTH-1:0]  fh;
        logic [`AC_SYMBOL_WIDTH-1:0] symbol;
        logic [`AC_SYMBOL_WIDTH:0]   nsyms;
        ac_mode_e                    mode;
    } ac_sym_req_t;

    // stage 1 to stage 2, bounds already shifted right by 6
    typedef struct packed {
        logic [`AC_RANGE_WIDTH-7:0] fl_s;
        logic [`AC_RANGE_WIDTH-7:0] fh_s;
        logic [`AC_RANGE_WIDTH-1:0] uu;
        logic [`AC_RANGE_WIDTH-1:0] vv;
        logic                       comp_low;
        logic                       bool_bit;
        ac_mode_e                   mode;
    } ac_prob_t;

    // stage 2 to stage 3
    typedef struct packed {
        logic [`AC_RANGE_WIDTH:0]   add_low;
        logic [`AC_D_SIZE-1:0]      d;
        logic [`AC_RANGE_WIDTH-1:0] range_out;
    } ac_interval_t;

    // reported coder state
    typedef struct packed {
        logic [`AC_RANGE_WIDTH-1:0] range;
        logic [`AC_LOW_WIDTH-1:0]   low;
        logic [`AC_D_SIZE-1:0]      s;
    } ac_state_t;

endpackage

// File: ac_control.sv
`include "ac_consts.svh"

module ac_control (
    input  logic                general_clk,
    input  logic                reset,
    input  logic                in_valid,
    input  ac_pkg::ac_sym_req_t in_sym,
    input  logic                out_credit_grant,
    output logic                in_credit,
    output ac_pkg::ac_sym_req_t head_sym,
    output logic                adv_1,
    output logic                adv_2,
    output logic                adv_3,
    output logic                out_valid
);
    import ac_pkg::*;

    localparam int QDEPTH = `AC_IN_CREDITS;
    localparam int PTR_W  = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
    localparam int CNT_W  = $clog2(QDEPTH + 1);
    localparam int CRED_W = $clog2(`AC_OUT_CREDITS + 1);

    typedef enum logic {
        CRED_IDLE    = 1'b0,
        CRED_RUNNING = 1'b1
    } cred_state_e;

    ac_sym_req_t       queue [QDEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  q_count;
    logic              v1;
    logic              v2;
    logic              v3;
    logic [CRED_W-1:0] credit_cnt;
    logic [CRED_W-1:0] credit_next;
    cred_state_e       cred_state;
    logic              advance;
    logic              take;

    // ---------------------------------------------------------------------------
    // advance enables
    // ---------------------------------------------------------------------------
    // whole pipeline moves unless a result is stuck without credit
    assign advance   = !v3 || (cred_state == CRED_RUNNING);
    assign take      = advance && (q_count != '0);
    assign out_valid = v3 && (cred_state == CRED_RUNNING);
    assign adv_1     = take;
    assign adv_2     = advance && v1;
    assign adv_3     = advance && v2;
    assign in_credit = take;
    assign head_sym  = queue[rd_ptr];

    // ---------------------------------------------------------------------------
    // input queue
    // ---------------------------------------------------------------------------
    always_ff @(posedge general_clk) begin
        if (in_valid) begin
            queue[wr_ptr] <= in_sym;
        end
    end

    always_ff @(posedge general_clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, take})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // stage valid bits, bubbles shift along with data
    always_ff @(posedge general_clk) begin
        if (reset) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else if (advance) begin
            v1 <= take;
            v2 <= v1;
            v3 <= v2;
        end
    end

    // ---------------------------------------------------------------------------
    // output credits
    // ---------------------------------------------------------------------------
    always_comb begin
        case ({out_credit_grant, out_valid})
            2'b10:   credit_next = credit_cnt + 1'b1;
            2'b01:   credit_next = credit_cnt - 1'b1;
            default: credit_next = credit_cnt;
        endcase
    end

    always_ff @(posedge general_clk) begin
        if (reset) begin
            credit_cnt <= '0;
            cred_state <= CRED_IDLE;
        end else begin
            credit_cnt <= credit_next;
            cred_state <= (credit_next != '0) ? CRED_RUNNING : CRED_IDLE;
        end
    end

    // sender must wait for a returned credit
    a_no_write_full: assert property (@(posedge general_clk) disable iff (reset)
        in_valid |-> q_count != CNT_W'(QDEPTH))
        else $error("input queue written while full");

    a_credit_no_underflow: assert property (@(posedge general_clk) disable iff (reset)
        credit_cnt == '0 |=> credit_cnt <= CRED_W'(1))
        else $error("output credit counter underflow");

    a_valid_needs_credit: assert property (@(posedge general_clk) disable iff (reset)
        out_valid |-> credit_cnt != '0)
        else $error("out_valid raised with zero credits");

endmodule

// File: ac_prob_stage.sv
`include "ac_consts.svh"

module ac_prob_stage (
    input  logic                general_clk,
    input  logic                adv_1,
    input  ac_pkg::ac_sym_req_t sym,
    output ac_pkg::ac_prob_t    prob
);
    import ac_pkg::*;

    localparam int RW = `AC_RANGE_WIDTH;

    logic [RW-1:0] left_cnt;
    logic [RW-1:0] uu_multi;
    logic [RW-1:0] vv_multi;
    ac_prob_t      prob_d;

    // ---------------------------------------------------------------------------
    // probability scaling and min-prob offsets
    // ---------------------------------------------------------------------------
    always_comb begin
        // symbols above the current one, each gets MIN_PROB
        left_cnt = RW'(sym.nsyms) - RW'(sym.symbol);
        uu_multi = RW'(`AC_MIN_PROB) * left_cnt;
        vv_multi = RW'(`AC_MIN_PROB) * (left_cnt - 1'b1);

        prob_d.fl_s     = sym.fl[RW-1:6];
        prob_d.fh_s     = sym.fh[RW-1:6];
        prob_d.comp_low = !sym.fl[RW-1];
        prob_d.bool_bit = sym.symbol[0];
        prob_d.mode     = sym.mode;

        if (sym.mode == AC_MODE_BOOL) begin
            // bool only has the single upper bound
            prob_d.uu = '0;
            prob_d.vv = RW'(`AC_MIN_PROB);
        end else begin
            prob_d.uu = uu_multi;
            prob_d.vv = vv_multi;
        end
    end

    always_ff @(posedge general_clk) begin
        if (adv_1) begin
            prob <= prob_d;
        end
    end

endmodule

// File: ac_range_stage.sv
`include "ac_consts.svh"

module ac_range_stage (
    input  logic                 general_clk,
    input  logic                 reset,
    input  logic                 adv_2,
    input  ac_pkg::ac_prob_t     prob,
    output ac_pkg::ac_interval_t interval
);
    import ac_pkg::*;

    localparam int RW = `AC_RANGE_WIDTH;
    localparam int DW = `AC_D_SIZE;

    logic [RW-1:0] range_q;
    logic [7:0]    r_top;
    logic [RW+1:0] prod_l;
    logic [RW+1:0] prod_h;
    logic [RW:0]   u;
    logic [RW:0]   v;
    logic [RW:0]   add_low;
    logic [RW-1:0] new_range;
    logic [RW-1:0] range_norm;
    logic [DW-1:0] d;

    // left shift that brings the top set bit to bit 15
    function automatic logic [DW-1:0] norm_shift(input logic [RW-1:0] r);
        logic [DW-1:0] sh;
        sh = '0;
        for (int i = 0; i < RW; i++) begin
            if (r[i]) begin
                sh = DW'(RW - 1 - i);
            end
        end
        return sh;
    endfunction

    // ---------------------------------------------------------------------------
    // interval split
    // ---------------------------------------------------------------------------
    // range_q already holds the predecessor's result
    assign r_top  = range_q[RW-1:8];
    assign prod_l = (RW+2)'(r_top) * (RW+2)'(prob.fl_s);
    assign prod_h = (RW+2)'(r_top) * (RW+2)'(prob.fh_s);
    assign u      = (RW+1)'(prod_l >> 1) + (RW+1)'(prob.uu);
    assign v      = (RW+1)'(prod_h >> 1) + (RW+1)'(prob.vv);

    always_comb begin
        add_low   = '0;
        new_range = RW'((RW+1)'(range_q) - v);
        if (prob.mode == AC_MODE_MULTI) begin
            if (prob.comp_low) begin
                add_low   = (RW+1)'(range_q) - u;
                new_range = RW'(u - v);
            end
        end else if (prob.bool_bit) begin
            add_low   = (RW+1)'(range_q) - v;
            new_range = RW'(v);
        end
    end

    // ---------------------------------------------------------------------------
    // normalization
    // ---------------------------------------------------------------------------
    assign d          = norm_shift(new_range);
    assign range_norm = new_range << d;

    always_ff @(posedge general_clk) begin
        if (reset) begin
            range_q <= RW'(`AC_RANGE_RESET);
        end else if (adv_2) begin
            range_q <= range_norm;
        end
    end

    always_ff @(posedge general_clk) begin
        if (adv_2) begin
            interval.add_low   <= add_low;
            interval.d         <= d;
            interval.range_out <= range_norm;
        end
    end

    // feedback register stays normalized
    a_range_normalized: assert property (@(posedge general_clk) disable iff (reset)
        adv_2 |=> range_q[RW-1])
        else $error("normalized range lost its top bit");

endmodule

// File: ac_low_stage.sv
`include "ac_consts.svh"

module ac_low_stage (
    input  logic                 general_clk,
    input  logic                 reset,
    input  logic                 adv_3,
    input  ac_pkg::ac_interval_t interval,
    output ac_pkg::ac_state_t    state
);
    import ac_pkg::*;

    localparam int RW = `AC_RANGE_WIDTH;
    localparam int LW = `AC_LOW_WIDTH;
    localparam int DW = `AC_D_SIZE;

    logic [LW-1:0] low_sum;
    logic [LW-1:0] low_next;
    logic [DW-1:0] s_sum;
    logic [DW-1:0] s_next;

    // ---------------------------------------------------------------------------
    // low update
    // ---------------------------------------------------------------------------
    // bits shifted past bit 23 would be carries into emitted bytes
    assign low_sum  = state.low + LW'(interval.add_low);
    assign low_next = low_sum << interval.d;

    // bit counter, one byte taken out per crossing
    assign s_sum  = state.s + interval.d;
    assign s_next = (s_sum >= DW'(8)) ? s_sum - DW'(8) : s_sum;

    always_ff @(posedge general_clk) begin
        if (reset) begin
            state.range <= RW'(`AC_RANGE_RESET);
            state.low   <= '0;
            state.s     <= '0;
        end else if (adv_3) begin
            state.range <= interval.range_out;
            state.low   <= low_next;
            state.s     <= s_next;
        end
    end

endmodule

// File: arithmetic_encoder.sv
module arithmetic_encoder (
    input  logic                general_clk,
    input  logic                reset,
    input  logic                in_valid,
    input  ac_pkg::ac_sym_req_t in_sym,
    input  logic                out_credit_grant,
    output logic                in_credit,
    output logic                out_valid,
    output ac_pkg::ac_state_t   out_state
);
    import ac_pkg::*;

    ac_sym_req_t  head_sym;
    ac_prob_t     prob;
    ac_interval_t interval;
    logic         adv_1;
    logic         adv_2;
    logic         adv_3;

    // ---------------------------------------------------------------------------
    // control, queue and credits
    // ---------------------------------------------------------------------------
    ac_control u_control (
        .general_clk      (general_clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_sym           (in_sym),
        .out_credit_grant (out_credit_grant),
        .in_credit        (in_credit),
        .head_sym         (head_sym),
        .adv_1            (adv_1),
        .adv_2            (adv_2),
        .adv_3            (adv_3),
        .out_valid        (out_valid)
    );

    // ---------------------------------------------------------------------------
    // datapath stages
    // ---------------------------------------------------------------------------
    ac_prob_stage u_prob_stage (
        .general_clk (general_clk),
        .adv_1       (adv_1),
        .sym         (head_sym),
        .prob        (prob)
    );

    ac_range_stage u_range_stage (
        .general_clk (general_clk),
        .reset       (reset),
        .adv_2       (adv_2),
        .prob        (prob),
        .interval    (interval)
    );

    // result register lives here
    ac_low_stage u_low_stage (
        .general_clk (general_clk),
        .reset       (reset),
        .adv_3       (adv_3),
        .interval    (interval),
        .state       (out_state)
    );

endmodule

// File: tb_arithmetic_encoder.sv
`include "ac_consts.svh"

module tb_arithmetic_encoder;
    import ac_pkg::*;

    localparam int NUM_PAT    = 12;
    localparam int COLS       = 9;
    localparam int MAX_CYCLES = 1000;

    logic        general_clk;
    logic        reset;
    logic        in_valid;
    ac_sym_req_t in_sym;
    logic        out_credit_grant;
    logic        in_credit;
    logic        out_valid;
    ac_state_t   out_state;

    logic [31:0] pat_mem [NUM_PAT*COLS];
    integer      seed;
    int          send_idx;
    int          recv_idx;
    int          in_credits;
    int          out_credits;
    int          grants_owed;
    int          hold_cnt;
    int          cycles;
    logic        send_now;
    logic        grant_now;

    arithmetic_encoder u_dut (
        .general_clk      (general_clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_sym           (in_sym),
        .out_credit_grant (out_credit_grant),
        .in_credit        (in_credit),
        .out_valid        (out_valid),
        .out_state        (out_state)
    );

    initial begin
        general_clk = 1'b0;
        forever #2 general_clk = ~general_clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // one symbol request from a pattern line
    function automatic ac_sym_req_t pattern_sym(input int idx);
        ac_sym_req_t sym;
        int          base;
        base       = idx * COLS;
        sym.fl     = pat_mem[base][15:0];
        sym.fh     = pat_mem[base+1][15:0];
        sym.symbol = pat_mem[base+2][3:0];
        sym.nsyms  = pat_mem[base+3][4:0];
        sym.mode   = ac_mode_e'(pat_mem[base+4][0]);
        return sym;
    endfunction

    task automatic check_result(input int idx);
        int base;
        base = idx * COLS;
        check_value("out_state.range", 32'(out_state.range), pat_mem[base+6]);
        check_value("out_state.low", 32'(out_state.low), pat_mem[base+7]);
        check_value("out_state.s", 32'(out_state.s), pat_mem[base+8]);
    endtask

    // ---------------------------------------------------------------------------
    // stimulus and checking
    // ---------------------------------------------------------------------------
    initial begin
        seed             = 32'h49af_7d9f;
        reset            = 1'b1;
        in_valid         = 1'b0;
        in_sym           = '0;
        out_credit_grant = 1'b0;
        send_idx         = 0;
        recv_idx         = 0;
        in_credits       = `AC_IN_CREDITS;
        out_credits      = 0;
        grants_owed      = `AC_OUT_CREDITS;
        hold_cnt         = 0;
        cycles           = 0;
        $readmemh("ac_patterns.txt", pat_mem);

        // outputs stay quiet while in reset
        repeat (4) begin
            @(posedge general_clk);
            @(negedge general_clk);
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("in_credit", 32'(in_credit), 32'd0);
        end
        @(posedge general_clk);
        reset <= 1'b0;

        while (recv_idx < NUM_PAT) begin
            @(negedge general_clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                report_failure("timeout: encoder stopped delivering results");
            end
            if (in_credit) begin
                in_credits++;
            end
            if (in_credits > `AC_IN_CREDITS) begin
                report_failure("encoder returned more input credits than symbols sent");
            end
            if (out_valid) begin
                if (out_credits == 0) begin
                    report_failure("out_valid raised without a granted credit");
                end
                if (recv_idx >= send_idx) begin
                    report_failure("more results than symbols sent");
                end
                check_result(recv_idx);
                out_credits--;
                grants_owed++;
                // stall marker holds grants back long enough to drain credits
                if (pat_mem[recv_idx*COLS+5][0]) begin
                    hold_cnt = 6 + ($random(seed) & 7);
                end
                recv_idx++;
            end
            if (out_credit_grant) begin
                out_credits++;
            end

            // decide what the next cycle drives
            send_now  = (in_credits > 0) && (send_idx < NUM_PAT) && (($random(seed) & 7) != 0);
            grant_now = (grants_owed > 0) && (hold_cnt == 0) && (($random(seed) & 3) != 0);
            if (hold_cnt > 0) begin
                hold_cnt--;
            end

            @(posedge general_clk);
            in_valid         <= send_now;
            out_credit_grant <= grant_now;
            if (send_now) begin
                in_sym <= pattern_sym(send_idx);
                send_idx++;
                in_credits--;
            end
            if (grant_now) begin
                grants_owed--;
            end
        end

        @(posedge general_clk);
        in_valid         <= 1'b0;
        out_credit_grant <= 1'b0;

        // nothing duplicated after the last result
        repeat (10) begin
            @(negedge general_clk);
            check_value("out_valid", 32'(out_valid), 32'd0);
        end

        if (recv_idx == NUM_PAT && send_idx == NUM_PAT && in_credits == `AC_IN_CREDITS) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("result count or input credit balance wrong at end of run");
            $display("SOME TESTS FAILED");
            $fatal(1, "run stopped");
        end
    end

endmodule

// File: project.f
+incdir+.
ac_pkg.sv
ac_control.sv
ac_prob_stage.sv
ac_range_stage.sv
ac_low_stage.sv
arithmetic_encoder.sv
tb_arithmetic_encoder.sv

// File: build_sim.sh
#!/bin/sh
# compile and run the arithmetic encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f project.f \
    --top-module tb_arithmetic_encoder --Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_arithmetic_encoder 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// File: ac_patterns.txt
// columns: fl fh symbol nsyms mode(1=bool) stall exp_range exp_low exp_s
// stall=1 withholds output credit grants for a while after that result
8000 6000 0 04 0 0 FFA0 000000 03
4000 2000 2 04 0 0 FF10 020060 05
5DC0 4E20 1 05 0 1 FB20 1224E0 00
0000 4000 1 02 1 0 FB08 2544F8 01
0000 7530 0 02 1 0 ACB0 2A27C0 04
0000 0800 1 02 1 1 AC40 AC9AC0 00
8000 7C00 0 10 0 0 AC80 935800 05
1000 0000 F 10 0 0 AC20 9F77E0 00
4E20 2EE0 1 03 0 1 A808 7EECA0 02
8000 4000 0 02 0 0 A808 FDD940 03
0000 0400 1 02 1 0 A880 CF8080 00
0000 4000 0 02 1 0 A8F8 9F0100 01
